// File: compile.f
+incdir+src
src/crtc_pkg.sv
src/crtc_regs.sv
src/crt_timing.sv
src/vram_dma.sv
src/row_buffer.sv
src/dot_renderer.sv
src/video_out.sv
src/pc_crtc_top.sv
test/tb_pc_crtc.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --top-module tb_pc_crtc -f compile.f -o tb_pc_crtc \
   && ./obj_dir/tb_pc_crtc | tee /dev/stderr | grep -q "TEST PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: src/crt_timing.sv
/* Line and frame counters, raw syncs, display enables and the
   character line and row counters */
`timescale 1ns/1ns
`include "crtc_params.svh"

module crt_timing (
   input  logic             I_CLK,
   input  logic             I_RST,
   input  crtc_pkg::cline_t lpc,
   output crtc_pkg::beam_t  beam
);
   import crtc_pkg::*;

   hpos_t  hcnt_q;
   vpos_t  vcnt_q;
   cline_t cline_q;
   crow_t  crow_q;
   logic   h_last;
   logic   line_end;
   logic   row_end;
   logic   frame_end;

   //////////////////////////////////////////////////////////////////////
   // 800 x 525 raster
   //////////////////////////////////////////////////////////////////////
   assign h_last = (hcnt_q == `CRTC_H_TOTAL - 10'd1);

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         hcnt_q <= '0;
         vcnt_q <= '0;
      end else if (h_last) begin
         hcnt_q <= '0;
         vcnt_q <= (vcnt_q == `CRTC_V_TOTAL - 10'd1) ? '0 : vcnt_q + 10'd1;
      end else begin
         hcnt_q <= hcnt_q + 10'd1;
      end
   end

   // Strobes at the last visible dot
   assign line_end  = (hcnt_q == `CRTC_H_DISP - 10'd1);
   assign frame_end = line_end && (vcnt_q == `CRTC_V_TOTAL - 10'd1);
   // Double scan so a row closes on the odd line
   assign row_end   = line_end && vcnt_q[0] && (cline_q == lpc);

   //////////////////////////////////////////////////////////////////////
   // Character line and row
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         cline_q <= '0;
         crow_q  <= '0;
      end else begin
         if (frame_end || row_end)
            cline_q <= '0;
         else if (line_end && vcnt_q[0])
            cline_q <= cline_q + 4'd1;
         if (frame_end)
            crow_q <= '0;
         else if (row_end)
            crow_q <= crow_q + 5'd1;
      end
   end

   // Syncs active low
   assign beam = '{
      hcnt:      hcnt_q,
      vcnt:      vcnt_q,
      hdisp:     (hcnt_q < `CRTC_H_DISP),
      vdisp:     (vcnt_q < `CRTC_V_DISP),
      hsync:     !(hcnt_q >= `CRTC_HS_START && hcnt_q < `CRTC_HS_END),
      vsync:     !(vcnt_q >= `CRTC_VS_START && vcnt_q < `CRTC_VS_END),
      cline:     cline_q,
      crow:      crow_q,
      line_end:  line_end,
      row_end:   row_end,
      frame_end: frame_end
   };

endmodule

// File: src/crtc_params.svh
/* Screen geometry, sync positions, VRAM layout and pipeline depth
   for the monochrome text CRT controller */
`ifndef CRTC_PARAMS_SVH
`define CRTC_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Horizontal timing in dot clocks
//////////////////////////////////////////////////////////////////////
`define CRTC_H_TOTAL    10'd800
`define CRTC_H_DISP     10'd640
`define CRTC_HS_START   10'd656
`define CRTC_HS_END     10'd752

//////////////////////////////////////////////////////////////////////
// Vertical timing in scanlines
//////////////////////////////////////////////////////////////////////
`define CRTC_V_TOTAL    10'd525
`define CRTC_V_DISP     10'd400
`define CRTC_VS_START   10'd490
`define CRTC_VS_END     10'd492

// Text bytes per row, also row buffer depth
`define CRTC_COLS       7'd80
// VRAM bytes per row, text plus the old attribute area
`define CRTC_ROW_STRIDE 15'd120
`define CRTC_VRAM_BASE  15'h7300

// Enable delay to line up with the dot pipeline
`define CRTC_PIPE_LAT   8
// 10 lines per character out of reset
`define CRTC_LPC_RESET  4'd9

`endif

// File: src/crtc_pkg.sv
/* Shared types of the CRT controller: counters, display settings,
   beam state, row buffer write and pixel records */
package crtc_pkg;

   typedef logic [9:0]  hpos_t;
   typedef logic [9:0]  vpos_t;
   typedef logic [6:0]  col_t;
   typedef logic [3:0]  cline_t;
   typedef logic [4:0]  crow_t;
   typedef logic [14:0] vram_adr_t;

   // Display settings written by the CPU
   typedef struct packed {
      logic   width80;
      cline_t lpc;
      col_t   xcurs;
      crow_t  ycurs;
   } crtc_cfg_t;

   // Beam position and its derived strobes
   typedef struct packed {
      hpos_t  hcnt;
      vpos_t  vcnt;
      logic   hdisp;
      logic   vdisp;
      logic   hsync;
      logic   vsync;
      cline_t cline;
      crow_t  crow;
      logic   line_end;
      logic   row_end;
      logic   frame_end;
   } beam_t;

   typedef struct packed {
      logic       we;
      col_t       adr;
      logic [7:0] data;
   } rowbuf_wr_t;

   typedef struct packed {
      logic dot;
      logic hsync;
      logic vsync;
   } pix_t;

endpackage

// File: src/crtc_regs.sv
/* Input retiming and port 30 / CRTC command-parameter decoding */
`timescale 1ns/1ns
`include "crtc_params.svh"

module crtc_regs (
   input  logic               I_CLK,
   input  logic               I_RST,
   input  logic               port30_we,
   input  logic               crtc_we,
   input  logic               adr,
   input  logic [7:0]         data,
   input  logic [7:0]         ram_data,
   output logic [7:0]         rdata,
   input  logic               busack,
   output logic               busack_q,
   output crtc_pkg::crtc_cfg_t cfg
);

   //////////////////////////////////////////////////////////////////////
   // Retiming of CPU and bus inputs
   //////////////////////////////////////////////////////////////////////
   logic       p30_we_q;
   logic       crtc_we_q;
   logic       adr_q;
   logic [7:0] data_q;
   logic [2:0] seq_q;
   logic       cmd_we;
   logic       par_we;

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         p30_we_q  <= 1'b0;
         crtc_we_q <= 1'b0;
         busack_q  <= 1'b0;
      end else begin
         p30_we_q  <= port30_we;
         crtc_we_q <= crtc_we;
         busack_q  <= busack;
      end
   end

   // Data side
   always_ff @(posedge I_CLK) begin
      adr_q  <= adr;
      data_q <= data;
      rdata  <= ram_data;
   end

   // adr=1 command, adr=0 parameter
   assign cmd_we = crtc_we_q && adr_q;
   assign par_we = crtc_we_q && !adr_q;

   //////////////////////////////////////////////////////////////////////
   // Command and parameter sequencer
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         seq_q <= 3'd0;
         cfg   <= '{width80: 1'b0, lpc: `CRTC_LPC_RESET, xcurs: 7'd0, ycurs: 5'd0};
      end else begin
         if (p30_we_q)
            cfg.width80 <= data_q[0];
         if (cmd_we) begin
            // Reset command starts a 5-parameter run
            if (data_q == 8'h00)
               seq_q <= 3'd5;
            // Cursor off parks it below the screen
            if (data_q == 8'h80)
               cfg.ycurs <= 5'd31;
            // Cursor on takes X then Y
            if (data_q == 8'h81)
               seq_q <= 3'd7;
         end
         if (par_we) begin
            if (seq_q == 3'd3)
               cfg.lpc <= data_q[3:0];
            if (seq_q == 3'd7)
               cfg.xcurs <= data_q[6:0];
            if (seq_q == 3'd6)
               cfg.ycurs <= data_q[4:0];
            // Y is the last cursor parameter
            if (seq_q != 3'd0)
               seq_q <= (seq_q == 3'd6) ? 3'd0 : seq_q - 3'd1;
         end
      end
   end

   // Parameters only arrive inside an open command run
   a_par_in_run: assert property (@(posedge I_CLK) disable iff (I_RST)
      par_we |-> (seq_q != 3'd0));

endmodule

// File: src/dot_renderer.sv
/* Text column walk, 2x4 block graphic dots, line blanking, cursor
   and the dot shifter */
`timescale 1ns/1ns

module dot_renderer (
   input  logic                I_CLK,
   input  logic                I_RST,
   input  crtc_pkg::beam_t     beam,
   input  crtc_pkg::crtc_cfg_t cfg,
   output crtc_pkg::col_t      rd_col,
   input  logic [7:0]          rd_data,
   output crtc_pkg::pix_t      pix
);
   import crtc_pkg::*;

   col_t       col_q;
   logic [7:0] shift_q;
   logic       curs_q;
   logic       load;
   logic       shift_en;
   logic       show;
   logic [1:0] nib_sel;
   logic       dot_l;
   logic       dot_r;

   //////////////////////////////////////////////////////////////////////
   // Character boundary and dot step
   //////////////////////////////////////////////////////////////////////
   // Load one dot early to cover the buffer read
   // 40 columns load every other boundary
   assign load     = (beam.hcnt[2:0] == 3'd6) && (cfg.width80 || !beam.hcnt[3]);
   // Dot doubling in 40 columns
   assign shift_en = cfg.width80 || !beam.hcnt[0];
   assign show     = beam.hdisp && beam.vdisp;

   // Text column, also the buffer read address
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST)
         col_q <= '0;
      else if (beam.line_end)
         col_q <= '0;
      else if (load && beam.hdisp)
         col_q <= col_q + 7'd1;
   end

   assign rd_col = col_q;

   //////////////////////////////////////////////////////////////////////
   // Block graphic
   //////////////////////////////////////////////////////////////////////
   // Cell rows of two character lines each
   assign nib_sel = beam.cline[2:1];
   // Low nibble left half, high nibble right half
   assign dot_l   = rd_data[{1'b0, nib_sel}];
   assign dot_r   = rd_data[{1'b1, nib_sel}];

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         shift_q <= 8'h00;
         curs_q  <= 1'b0;
      end else if (load) begin
         // Lines 8 and 9 stay dark
         if (show && !beam.cline[3])
            shift_q <= {{4{dot_l}}, {4{dot_r}}};
         else
            shift_q <= 8'h00;
         // Whole cell including the dark lines
         curs_q <= show && (col_q == cfg.xcurs) && (beam.crow == cfg.ycurs);
      end else if (shift_en) begin
         shift_q <= {shift_q[6:0], 1'b0};
      end
   end

   // Pixel stage
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         pix <= '0;
      end else begin
         pix.dot   <= shift_q[7] ^ curs_q;
         pix.hsync <= beam.hsync;
         pix.vsync <= beam.vsync;
      end
   end

endmodule

// File: src/pc_crtc_top.sv
/* CRT controller top: register decode, timing, DMA, row buffer,
   dot renderer and video output */
`timescale 1ns/1ns

module pc_crtc_top (
   input  logic                I_CLK,
   input  logic                I_RST,
   input  logic                port30_we,
   input  logic                crtc_we,
   input  logic                adr,
   input  logic [7:0]          data,
   input  logic [7:0]          ram_data,
   input  logic                busack,
   output crtc_pkg::vram_adr_t ram_adr,
   output logic                busreq,
   output logic [3:0]          vga_r,
   output logic [3:0]          vga_g,
   output logic [3:0]          vga_b,
   output logic                vga_hs,
   output logic                vga_vs
);
   import crtc_pkg::*;

   crtc_cfg_t  cfg;
   beam_t      beam;
   rowbuf_wr_t wr;
   pix_t       pix;
   col_t       rd_col;
   logic [7:0] rdata;
   logic [7:0] rd_data;
   logic       busack_q;

   //////////////////////////////////////////////////////////////////////
   // Input side
   //////////////////////////////////////////////////////////////////////
   crtc_regs u_regs (
      .I_CLK(I_CLK), .I_RST(I_RST), .port30_we(port30_we), .crtc_we(crtc_we),
      .adr(adr), .data(data), .ram_data(ram_data), .rdata(rdata),
      .busack(busack), .busack_q(busack_q), .cfg(cfg)
   );

   crt_timing u_timing (.I_CLK(I_CLK), .I_RST(I_RST), .lpc(cfg.lpc), .beam(beam));

   // Row fetch into the buffer
   vram_dma u_dma (
      .I_CLK(I_CLK), .I_RST(I_RST), .beam(beam), .busack(busack_q), .rdata(rdata),
      .ram_adr(ram_adr), .busreq(busreq), .wr(wr)
   );

   row_buffer u_rowbuf (.I_CLK(I_CLK), .wr(wr), .rd_col(rd_col), .rd_data(rd_data));

   //////////////////////////////////////////////////////////////////////
   // Output side
   //////////////////////////////////////////////////////////////////////
   dot_renderer u_render (
      .I_CLK(I_CLK), .I_RST(I_RST), .beam(beam), .cfg(cfg),
      .rd_col(rd_col), .rd_data(rd_data), .pix(pix)
   );

   video_out u_vout (
      .I_CLK(I_CLK), .I_RST(I_RST), .beam(beam), .pix(pix),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
   );

endmodule

// File: src/row_buffer.sv
/* One-row text buffer with registered read */
`timescale 1ns/1ns
`include "crtc_params.svh"

module row_buffer (
   input  logic                 I_CLK,
   input  crtc_pkg::rowbuf_wr_t wr,
   input  crtc_pkg::col_t       rd_col,
   output logic [7:0]           rd_data
);

   // One byte per text column
   logic [7:0] mem [0:`CRTC_COLS-1];

   always_ff @(posedge I_CLK) begin
      if (wr.we)
         mem[wr.adr] <= wr.data;
   end

   // Data valid the cycle after the address
   always_ff @(posedge I_CLK) begin
      rd_data <= mem[rd_col];
   end

   // DMA column walk stays inside the row
   a_wr_in_row: assert property (@(posedge I_CLK)
      wr.we |-> (wr.adr < `CRTC_COLS));

endmodule

// File: src/video_out.sv
/* Enable and sync delay lines and the monochrome RGB drive */
`timescale 1ns/1ns
`include "crtc_params.svh"

module video_out (
   input  logic            I_CLK,
   input  logic            I_RST,
   input  crtc_pkg::beam_t beam,
   input  crtc_pkg::pix_t  pix,
   output logic [3:0]      vga_r,
   output logic [3:0]      vga_g,
   output logic [3:0]      vga_b,
   output logic            vga_hs,
   output logic            vga_vs
);

   localparam int LAT = `CRTC_PIPE_LAT;

   // Enables from the raw beam
   logic [LAT-1:0] hd_q;
   logic [LAT-1:0] vd_q;
   // Syncs already carry one renderer stage
   logic [LAT-2:0] hs_q;
   logic [LAT-2:0] vs_q;
   logic [3:0]     lum;

   // Full white on a lit dot inside the display
   assign lum = {4{pix.dot && hd_q[LAT-1] && vd_q[LAT-1]}};

   //////////////////////////////////////////////////////////////////////
   // Delay lines and output registers
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         hd_q   <= '0;
         vd_q   <= '0;
         hs_q   <= '0;
         vs_q   <= '0;
         vga_r  <= 4'h0;
         vga_g  <= 4'h0;
         vga_b  <= 4'h0;
         vga_hs <= 1'b0;
         vga_vs <= 1'b0;
      end else begin
         hd_q   <= {hd_q[LAT-2:0], beam.hdisp};
         vd_q   <= {vd_q[LAT-2:0], beam.vdisp};
         hs_q   <= {hs_q[LAT-3:0], pix.hsync};
         vs_q   <= {vs_q[LAT-3:0], pix.vsync};
         vga_r  <= lum;
         vga_g  <= lum;
         vga_b  <= lum;
         vga_hs <= hs_q[LAT-2];
         vga_vs <= vs_q[LAT-2];
      end
   end

endmodule

// File: src/vram_dma.sv
/* Per-row VRAM DMA: bus request, address walk and row buffer writes */
`timescale 1ns/1ns
`include "crtc_params.svh"

module vram_dma (
   input  logic                 I_CLK,
   input  logic                 I_RST,
   input  crtc_pkg::beam_t      beam,
   input  logic                 busack,
   input  logic [7:0]           rdata,
   output crtc_pkg::vram_adr_t  ram_adr,
   output logic                 busreq,
   output crtc_pkg::rowbuf_wr_t wr
);
   import crtc_pkg::*;

   vram_adr_t  base_q;
   col_t       count_q;
   logic       xfer;
   logic [1:0] we_q;
   col_t       adr_d1;
   col_t       adr_d2;

   // One byte per acknowledged cycle
   assign xfer = busreq && busack;

   //////////////////////////////////////////////////////////////////////
   // Transfer state and address walk
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         busreq  <= 1'b0;
         count_q <= '0;
         base_q  <= `CRTC_VRAM_BASE;
         ram_adr <= `CRTC_VRAM_BASE;
      end else if (beam.frame_end) begin
         // Top of screen for row 0
         busreq  <= 1'b1;
         count_q <= '0;
         base_q  <= `CRTC_VRAM_BASE;
         ram_adr <= `CRTC_VRAM_BASE;
      end else if (beam.row_end) begin
         // Skip over the unused attribute bytes
         busreq  <= 1'b1;
         count_q <= '0;
         base_q  <= base_q + `CRTC_ROW_STRIDE;
         ram_adr <= base_q + `CRTC_ROW_STRIDE;
      end else if (xfer) begin
         ram_adr <= ram_adr + 15'd1;
         count_q <= count_q + 7'd1;
         if (count_q == `CRTC_COLS - 7'd1)
            busreq <= 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Write alignment with the retimed read data
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST)
         we_q <= 2'b00;
      else
         we_q <= {we_q[0], xfer};
   end

   // Memory read stage then input retime stage
   always_ff @(posedge I_CLK) begin
      adr_d1 <= count_q;
      adr_d2 <= adr_d1;
   end

   assign wr = '{we: we_q[1], adr: adr_d2, data: rdata};

   // A new row or frame never cuts a running transfer short
   a_row_done_before_event: assert property (@(posedge I_CLK) disable iff (I_RST)
      (beam.row_end || beam.frame_end) |-> !busreq);

endmodule

// File: test/tb_pc_crtc.sv
/* Testbench for the CRT controller: VRAM model with DMA checks,
   register programming table and full-frame pixel and sync checks */
`timescale 1ns/1ns
`include "crtc_params.svh"

module tb_pc_crtc;
   import crtc_pkg::*;

   localparam int H_TOT    = `CRTC_H_TOTAL;
   localparam int H_DISP   = `CRTC_H_DISP;
   localparam int HS_START = `CRTC_HS_START;
   localparam int HS_END   = `CRTC_HS_END;
   localparam int V_TOT    = `CRTC_V_TOTAL;
   localparam int V_DISP   = `CRTC_V_DISP;
   localparam int VS_START = `CRTC_VS_START;
   localparam int VS_END   = `CRTC_VS_END;
   localparam int N_ENT    = 4;
   // From the vsync rise through line 479 of the next frame
   localparam int CHECK_CYCLES = (V_TOT - VS_END + 480) * H_TOT;
   localparam int FRAME_CYCLES = 420000;
   localparam int CYCLE_LIMIT  = N_ENT * 3 * FRAME_CYCLES;

   // One programming step and the geometry it must produce
   typedef struct packed {
      logic       w80;
      logic [3:0] lpc;
      logic [6:0] xcurs;
      logic [4:0] ycurs;
      logic [6:0] cols;
      logic [4:0] row_lines;
   } entry_t;

   logic       I_CLK;
   logic       I_RST;
   logic       port30_we;
   logic       crtc_we;
   logic       adr;
   logic [7:0] data;
   logic [7:0] ram_data;
   logic       busack;
   vram_adr_t  ram_adr;
   logic       busreq;
   logic [3:0] vga_r;
   logic [3:0] vga_g;
   logic [3:0] vga_b;
   logic       vga_hs;
   logic       vga_vs;

   logic [7:0]  vram [0:32767];
   entry_t      tbl [N_ENT];
   int          cycles;
   logic [1:0]  req_d;
   vram_adr_t   adr_prev;
   vram_adr_t   row_start;
   logic        busreq_prev;
   int          xfer_cnt;

   pc_crtc_top uut (
      .I_CLK(I_CLK), .I_RST(I_RST), .port30_we(port30_we), .crtc_we(crtc_we),
      .adr(adr), .data(data), .ram_data(ram_data), .busack(busack),
      .ram_adr(ram_adr), .busreq(busreq),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
   );

   // 40 ns period
   always #20 I_CLK = ~I_CLK;

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////
   // Taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic compare(input logic [31:0] act, input logic [31:0] exp, input string what);
      if (act !== exp) begin
         $display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, act, exp);
         $display("TEST FAIL");
         $fatal(1);
      end
   endtask

   // Pixel rule with 2x4 blocks, dark lines 8-9 and an inverted cursor cell
   function automatic logic [3:0] ref_rgb(input int h, input int v, input entry_t t);
      int         crow;
      int         cline;
      int         cw;
      int         c;
      int         k;
      logic [7:0] b;
      logic       dot;
      if (h >= H_DISP || v >= V_DISP)
         return 4'h0;
      crow  = v / int'(t.row_lines);
      cline = (v % int'(t.row_lines)) / 2;
      // Cell width in dots, eight dots per cell
      cw    = H_DISP / int'(t.cols);
      c     = h / cw;
      k     = (h % cw) / (cw / 8);
      b   = vram[15'(`CRTC_VRAM_BASE + `CRTC_ROW_STRIDE * crow + c)];
      dot = 1'b0;
      if (cline < 8)
         dot = (k < 4) ? b[cline / 2] : b[4 + cline / 2];
      if (c == int'(t.xcurs) && crow == int'(t.ycurs))
         dot = !dot;
      return dot ? 4'hF : 4'h0;
   endfunction

   task automatic port30_write(input logic [7:0] d);
      port30_we = 1'b1;
      data      = d;
      @(negedge I_CLK);
      port30_we = 1'b0;
   endtask

   task automatic crtc_write(input logic a, input logic [7:0] d);
      crtc_we = 1'b1;
      adr     = a;
      data    = d;
      @(negedge I_CLK);
      crtc_we = 1'b0;
   endtask

   // Reset command, lpc is the third parameter, then cursor X and Y
   task automatic program_regs(input entry_t t);
      port30_write({7'd0, t.w80});
      crtc_write(1'b1, 8'h00);
      crtc_write(1'b0, 8'h00);
      crtc_write(1'b0, 8'h00);
      crtc_write(1'b0, {4'd0, t.lpc});
      crtc_write(1'b0, 8'h00);
      crtc_write(1'b0, 8'h00);
      crtc_write(1'b1, 8'h81);
      crtc_write(1'b0, {1'b0, t.xcurs});
      crtc_write(1'b0, {3'd0, t.ycurs});
   endtask

   task automatic wait_vs_rise();
      logic prev;
      prev = vga_vs;
      @(negedge I_CLK);
      while (!(vga_vs && !prev)) begin
         prev = vga_vs;
         @(negedge I_CLK);
      end
   endtask

   // Entered in the first cycle with vsync high at pixel (0, VS_END)
   task automatic check_frame(input entry_t t);
      int h;
      int v;
      int n;
      h = 0;
      v = VS_END;
      for (n = 0; n < CHECK_CYCLES; n++) begin
         compare(32'(vga_hs), 32'(h < HS_START || h >= HS_END), "hsync");
         compare(32'(vga_vs), 32'(v < VS_START || v >= VS_END), "vsync");
         compare(32'(vga_r), 32'(ref_rgb(h, v, t)), "red");
         compare(32'(vga_g), 32'(ref_rgb(h, v, t)), "green");
         compare(32'(vga_b), 32'(ref_rgb(h, v, t)), "blue");
         @(negedge I_CLK);
         h = h + 1;
         if (h == H_TOT) begin
            h = 0;
            v = (v == V_TOT - 1) ? 0 : v + 1;
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // VRAM model and DMA monitor
   //////////////////////////////////////////////////////////////////////
   always @(negedge I_CLK) begin
      if (!I_RST) begin
         // New row must start at the base or one stride on
         if (busreq && !busreq_prev) begin
            compare(32'(ram_adr == `CRTC_VRAM_BASE
                        || ram_adr == row_start + `CRTC_ROW_STRIDE), 32'd1, "DMA row base");
            row_start = ram_adr;
            xfer_cnt  = 0;
         end
         // Current busack is what the DUT retimed this cycle
         if (busreq && busack) begin
            compare(32'(ram_adr), 32'(15'(row_start + xfer_cnt)), "DMA address");
            xfer_cnt = xfer_cnt + 1;
         end
         if (!busreq && busreq_prev)
            compare(32'(xfer_cnt), 32'd80, "DMA byte count");
      end
      busreq_prev = busreq;
      // Byte of the address seen one cycle earlier
      ram_data = vram[adr_prev];
      adr_prev = ram_adr;
      // Acknowledge two cycles after the request
      req_d  = {req_d[0], busreq};
      busack = busreq && req_d[1];
   end

   // Run limit
   always @(posedge I_CLK) begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("Simulation ran past its cycle limit without finishing");
         $display("TEST FAIL");
         $fatal(1);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin : main
      logic [31:0] s;
      logic [7:0]  b;
      int          a;
      int          i;
      int          e;
      I_CLK       = 1'b0;
      I_RST       = 1'b1;
      port30_we   = 1'b0;
      crtc_we     = 1'b0;
      adr         = 1'b0;
      data        = 8'h00;
      ram_data    = 8'h00;
      busack      = 1'b0;
      cycles      = 0;
      req_d       = 2'b00;
      adr_prev    = '0;
      row_start   = `CRTC_VRAM_BASE;
      busreq_prev = 1'b0;
      xfer_cnt    = 0;
      // Eight LFSR bits per byte in address order
      s = 32'h5231_8f75;
      for (a = 0; a < 32768; a++) begin
         b = 8'h00;
         for (i = 0; i < 8; i++) begin
            b = {b[6:0], s[31]};
            s = lfsr_next(s);
         end
         vram[a] = b;
      end
      // 80 col 10 lines, 40 col 8 lines, cursor in the corners
      tbl[0] = '{w80: 1'b1, lpc: 4'd9, xcurs: 7'd5,  ycurs: 5'd3,  cols: 7'd80, row_lines: 5'd20};
      tbl[1] = '{w80: 1'b0, lpc: 4'd7, xcurs: 7'd12, ycurs: 5'd24, cols: 7'd40, row_lines: 5'd16};
      tbl[2] = '{w80: 1'b1, lpc: 4'd9, xcurs: 7'd79, ycurs: 5'd19, cols: 7'd80, row_lines: 5'd20};
      tbl[3] = '{w80: 1'b0, lpc: 4'd9, xcurs: 7'd0,  ycurs: 5'd0,  cols: 7'd40, row_lines: 5'd20};

      // Reset values
      @(posedge I_CLK);
      @(negedge I_CLK);
      compare(32'(busreq), 32'd0, "busreq in reset");
      compare(32'({vga_r, vga_g, vga_b}), 32'd0, "RGB in reset");
      @(negedge I_CLK);
      I_RST = 1'b0;
      // Sync delay lines filled
      repeat (12) @(negedge I_CLK);
      compare(32'({vga_hs, vga_vs}), 32'b11, "syncs after fill");

      for (e = 0; e < N_ENT; e++) begin
         program_regs(tbl[e]);
         wait_vs_rise();
         wait_vs_rise();
         check_frame(tbl[e]);
      end

      $display("TEST PASS");
      $finish;
   end

endmodule
